/* tb.f */
csr_pkg.sv
csr_op_decoder.sv
csr_slice.sv
csr_read_mux.sv
csr_unit.sv
csr_props.sv
tb_csr_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

# Build the simulation binary from the file list
if ! verilator --binary --timing --assert -j 0 -f tb.f \
        --top-module tb_csr_unit -o Vtb_csr_unit; then
    echo "Verilator build failed"
    exit 1
fi

# Run and keep the output for the search below
output=$(./obj_dir/Vtb_csr_unit)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* tb_csr_unit.sv */
`timescale 1ns/100ps

module tb_csr_unit;

    import csr_pkg::*;

    // Run length, used by the watchdog
    localparam int NUM_TESTS    = 5;
    localparam int OPS_PER_TEST = 100;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 8;
    // Twice the longest expected run, in ns
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * OPS_PER_TEST) * CLK_PERIOD * 2;

    logic       clk_i = 1'b0;
    logic       arst_n_i;
    csr_op_e    csr_op_i;
    csr_addr_t  csr_addr_i;
    csr_word_t  csr_wdata_i;
    logic       trap_i;
    csr_word_t  trap_mstatus_i;
    csr_word_t  trap_mtvec_i;
    csr_word_t  trap_mepc_i;
    csr_word_t  trap_mcause_i;
    csr_word_t  csr_rdata_o;
    logic       illegal_o;

    // Reference model of the four CSRs in slot order
    csr_word_t model_q [NUM_CSR];

    // Result counters
    int errors;
    int test_errors;
    int checks;
    int tests_run;
    int tests_failed;

    csr_unit dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .csr_op_i       (csr_op_i),
        .csr_addr_i     (csr_addr_i),
        .csr_wdata_i    (csr_wdata_i),
        .trap_i         (trap_i),
        .trap_mstatus_i (trap_mstatus_i),
        .trap_mtvec_i   (trap_mtvec_i),
        .trap_mepc_i    (trap_mepc_i),
        .trap_mcause_i  (trap_mcause_i),
        .csr_rdata_o    (csr_rdata_o),
        .illegal_o      (illegal_o)
    );

    // 8 ns clock
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Slot of an address in the CSR map, -1 if unmapped
    function automatic int find_slot(csr_addr_t addr);
        int slot;
        slot = -1;
        for (int i = 0; i < NUM_CSR; i++) begin
            if (addr == CSR_ADDR[i]) begin
                slot = i;
            end
        end
        return slot;
    endfunction

    // New CSR value after an instruction, WARL mask applied
    function automatic csr_word_t next_value(csr_op_e op, csr_word_t old, csr_word_t src,
                                             int slot);
        csr_word_t res;
        case (op)
            CSR_RW:  res = src;
            CSR_RS:  res = old | src;
            CSR_RC:  res = old & ~src;
            default: res = old;
        endcase
        return res & CSR_WMASK[slot];
    endfunction

    // Any op except CSR_NONE
    function automatic csr_op_e rand_op();
        csr_op_e op;
        case ($urandom_range(0, 2))
            0:       op = CSR_RW;
            1:       op = CSR_RS;
            default: op = CSR_RC;
        endcase
        return op;
    endfunction

    // Address outside the CSR map
    function automatic csr_addr_t rand_unmapped_addr();
        csr_addr_t addr;
        addr = csr_addr_t'($urandom);
        while (find_slot(addr) >= 0) begin
            addr = csr_addr_t'($urandom);
        end
        return addr;
    endfunction

    task automatic check_word(string name, csr_word_t exp, csr_word_t act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // One cycle: drive after the edge, check mid cycle, then advance the model
    task automatic step(csr_op_e op, csr_addr_t addr, csr_word_t wdata, logic trap);
        int         slot;
        csr_word_t  exp_rdata;
        logic       exp_illegal;
        @(posedge clk_i);
        #1;
        csr_op_i    = op;
        csr_addr_i  = addr;
        csr_wdata_i = wdata;
        trap_i      = trap;
        // Trap words change every cycle and must only matter with trap_i
        trap_mstatus_i = $urandom;
        trap_mtvec_i   = $urandom;
        trap_mepc_i    = $urandom;
        trap_mcause_i  = $urandom;
        @(negedge clk_i);
        slot        = find_slot(addr);
        exp_rdata   = (slot >= 0) ? model_q[slot] : '0;
        exp_illegal = (op != CSR_NONE) && (slot < 0);
        check_word("csr_rdata_o", exp_rdata, csr_rdata_o);
        check_flag("illegal_o", exp_illegal, illegal_o);
        // State seen after the coming edge
        if (trap) begin
            model_q[MSTATUS_SLOT] = trap_mstatus_i & CSR_WMASK[MSTATUS_SLOT];
            model_q[MTVEC_SLOT]   = trap_mtvec_i & CSR_WMASK[MTVEC_SLOT];
            model_q[MEPC_SLOT]    = trap_mepc_i & CSR_WMASK[MEPC_SLOT];
            model_q[MCAUSE_SLOT]  = trap_mcause_i & CSR_WMASK[MCAUSE_SLOT];
        end else if (op != CSR_NONE && slot >= 0) begin
            model_q[slot] = next_value(op, model_q[slot], wdata, slot);
        end
    endtask

    // Plain reads of every CSR
    task automatic read_all();
        for (int i = 0; i < NUM_CSR; i++) begin
            step(CSR_NONE, CSR_ADDR[i], $urandom, 1'b0);
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int slot;
        void'($urandom(1727));
        arst_n_i       = 1'b0;
        csr_op_i       = CSR_NONE;
        csr_addr_i     = '0;
        csr_wdata_i    = '0;
        trap_i         = 1'b0;
        trap_mstatus_i = '0;
        trap_mtvec_i   = '0;
        trap_mepc_i    = '0;
        trap_mcause_i  = '0;
        errors         = 0;
        test_errors    = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        for (int i = 0; i < NUM_CSR; i++) begin
            model_q[i] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // All CSRs come out of reset as zero
        read_all();
        end_test("reset values");

        // CSRRW, old value in the write cycle, masked value after it
        repeat (40) begin
            slot = $urandom_range(0, NUM_CSR - 1);
            step(CSR_RW, CSR_ADDR[slot], $urandom, 1'b0);
            step(CSR_NONE, CSR_ADDR[slot], $urandom, 1'b0);
        end
        end_test("random csrrw");

        // Mixed set and clear sequences
        repeat (60) begin
            slot = $urandom_range(0, NUM_CSR - 1);
            if ($urandom_range(0, 1) == 0) begin
                step(CSR_RS, CSR_ADDR[slot], $urandom, 1'b0);
            end else begin
                step(CSR_RC, CSR_ADDR[slot], $urandom, 1'b0);
            end
        end
        read_all();
        end_test("random csrrs and csrrc");

        // Trap with a colliding instruction write
        repeat (8) begin
            slot = $urandom_range(0, NUM_CSR - 1);
            step(rand_op(), CSR_ADDR[slot], $urandom, 1'b1);
            read_all();
        end
        end_test("trap over instruction write");

        // Unmapped addresses must not disturb any CSR
        // An idle cycle on an unmapped address reads zero and stays legal
        repeat (30) begin
            step(rand_op(), rand_unmapped_addr(), $urandom, 1'b0);
            step(CSR_NONE, rand_unmapped_addr(), $urandom, 1'b0);
        end
        read_all();
        end_test("unmapped addresses");

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_csr_unit

/* csr_props.sv */
`timescale 1ns/100ps

module csr_props (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  csr_pkg::csr_op_e    csr_op_i,
    input  logic                trap_i,
    input  csr_pkg::csr_word_t  trap_mcause_i,
    input  csr_pkg::csr_word_t  csr_rdata_o,
    input  logic                illegal_o,
    // Stored mcause value
    input  csr_pkg::csr_word_t  mcause_i
);

    import csr_pkg::*;

    // Unmapped access never leaks data
    a_illegal_reads_zero : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        illegal_o |-> (csr_rdata_o == '0))
        else $error("illegal access returned nonzero read data");

    // No op, no illegal flag
    a_idle_not_illegal : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (csr_op_i == CSR_NONE) |-> !illegal_o)
        else $error("illegal flag raised without an op");

    // mcause is fully writable so the trap word lands unchanged
    a_trap_loads_mcause : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        trap_i |=> (mcause_i == $past(trap_mcause_i)))
        else $error("mcause does not hold the trap word after a trap");

endmodule : csr_props

bind csr_unit csr_props u_props (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .csr_op_i      (csr_op_i),
    .trap_i        (trap_i),
    .trap_mcause_i (trap_mcause_i),
    .csr_rdata_o   (csr_rdata_o),
    .illegal_o     (illegal_o),
    .mcause_i      (slot_val[csr_pkg::MCAUSE_SLOT])
);

/* csr_unit.sv */
`timescale 1ns/100ps

module csr_unit (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // CSR instruction
    input  csr_pkg::csr_op_e    csr_op_i,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  csr_pkg::csr_word_t  csr_wdata_i,

    // Trap strobe
    input  logic                trap_i,

    // Trap data, one word per CSR
    input  csr_pkg::csr_word_t  trap_mstatus_i,
    input  csr_pkg::csr_word_t  trap_mtvec_i,
    input  csr_pkg::csr_word_t  trap_mepc_i,
    input  csr_pkg::csr_word_t  trap_mcause_i,

    // Read data of the addressed CSR
    output csr_pkg::csr_word_t  csr_rdata_o,

    // Access to an unmapped address
    output logic                illegal_o
);

    import csr_pkg::*;

    localparam int unsigned SEL_W = $clog2(NUM_CSR);

    // Decoder outputs
    logic [NUM_CSR-1:0] slot_we;
    logic [SEL_W-1:0]   slot_sel;
    logic               hit;

    // Trap words in slot order
    csr_word_t trap_data [NUM_CSR];

    // Slot contents towards the read mux
    csr_word_t slot_val [NUM_CSR];

    // Place each trap port at its slot
    assign trap_data[MSTATUS_SLOT] = trap_mstatus_i;
    assign trap_data[MTVEC_SLOT]   = trap_mtvec_i;
    assign trap_data[MEPC_SLOT]    = trap_mepc_i;
    assign trap_data[MCAUSE_SLOT]  = trap_mcause_i;

    // Address decode and illegal check
    csr_op_decoder u_decoder (
        .csr_op_i   (csr_op_i),
        .csr_addr_i (csr_addr_i),
        .slot_we_o  (slot_we),
        .slot_sel_o (slot_sel),
        .hit_o      (hit),
        .illegal_o  (illegal_o)
    );

    // One register slice per CSR
    for (genvar i = 0; i < NUM_CSR; i++) begin : g_slot
        csr_slice #(
            .SLOT (i)
        ) u_slice (
            .clk_i       (clk_i),
            .arst_n_i    (arst_n_i),
            .we_i        (slot_we[i]),
            .op_i        (csr_op_i),
            .wdata_i     (csr_wdata_i),
            .trap_i      (trap_i),
            .trap_data_i (trap_data[i]),
            .value_o     (slot_val[i])
        );
    end

    // Combinational read of the old value
    csr_read_mux u_read_mux (
        .slot_val_i  (slot_val),
        .slot_sel_i  (slot_sel),
        .hit_i       (hit),
        .csr_rdata_o (csr_rdata_o)
    );

endmodule : csr_unit

/* csr_read_mux.sv */
`timescale 1ns/100ps

module csr_read_mux (
    // Contents of every slot
    input  csr_pkg::csr_word_t                  slot_val_i [csr_pkg::NUM_CSR],

    // Slot chosen by the decoder
    input  logic [$clog2(csr_pkg::NUM_CSR)-1:0] slot_sel_i,

    // Decoder found a matching address
    input  logic                                hit_i,

    // Read data, old value of the addressed CSR
    output csr_pkg::csr_word_t                  csr_rdata_o
);

    import csr_pkg::*;

    // Value of the selected slot before the hit check
    csr_word_t sel_val;

    // Indexed pick of the slot
    assign sel_val = slot_val_i[slot_sel_i];

    // Unmapped address reads as zero
    // Select is left at zero on a miss so the pick alone would show mstatus
    always_comb begin
        if (hit_i) begin
            csr_rdata_o = sel_val;
        end else begin
            csr_rdata_o = '0;
        end
    end

endmodule : csr_read_mux

/* csr_slice.sv */
`timescale 1ns/100ps

module csr_slice #(
    // Slot index into the package tables
    parameter int unsigned SLOT = 0
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Instruction write for this slot
    input  logic                we_i,
    input  csr_pkg::csr_op_e    op_i,
    input  csr_pkg::csr_word_t  wdata_i,

    // Trap load
    input  logic                trap_i,
    input  csr_pkg::csr_word_t  trap_data_i,

    // Current register contents
    output csr_pkg::csr_word_t  value_o
);

    import csr_pkg::*;

    // Writable bits of this slot
    localparam csr_word_t MASK = CSR_WMASK[SLOT];

    csr_word_t value_q;

    // Raw read-modify-write result before masking
    csr_word_t rmw_val;

    // Result of the op on the stored value
    always_comb begin
        case (op_i)
            CSR_RW:  rmw_val = wdata_i;
            CSR_RS:  rmw_val = value_q | wdata_i;
            CSR_RC:  rmw_val = value_q & ~wdata_i;
            default: rmw_val = value_q;
        endcase
    end

    // Trap wins over any instruction write
    // Both paths go through the WARL mask
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            value_q <= '0;
        end else if (trap_i) begin
            value_q <= trap_data_i & MASK;
        end else if (we_i) begin
            value_q <= rmw_val & MASK;
        end
    end

    assign value_o = value_q;

endmodule : csr_slice

/* csr_op_decoder.sv */
`timescale 1ns/100ps

module csr_op_decoder (
    // CSR instruction
    input  csr_pkg::csr_op_e                    csr_op_i,
    input  csr_pkg::csr_addr_t                  csr_addr_i,

    // One-hot write enable per slot
    output logic [csr_pkg::NUM_CSR-1:0]         slot_we_o,

    // Matching slot index for the read path
    output logic [$clog2(csr_pkg::NUM_CSR)-1:0] slot_sel_o,

    // Address matched one of the slots
    output logic                                hit_o,

    // Active op on an unmapped address
    output logic                                illegal_o
);

    import csr_pkg::*;

    localparam int unsigned SEL_W = $clog2(NUM_CSR);

    // Raw address match per slot
    logic [NUM_CSR-1:0] addr_match;

    // An instruction is present this cycle
    logic op_valid;

    assign op_valid = (csr_op_i != CSR_NONE);

    // Compare the address against every table entry
    always_comb begin
        for (int i = 0; i < NUM_CSR; i++) begin
            addr_match[i] = (csr_addr_i == CSR_ADDR[i]);
        end
    end

    // Write enables only fire for a real instruction
    assign slot_we_o = op_valid ? addr_match : '0;

    // Encode the matching slot
    // Addresses are unique so at most one bit is set
    always_comb begin
        slot_sel_o = '0;
        for (int i = 0; i < NUM_CSR; i++) begin
            if (addr_match[i]) begin
                slot_sel_o = SEL_W'(i);
            end
        end
    end

    // Hit is independent of the op so a read works on any cycle
    assign hit_o = |addr_match;

    // Unknown address with a live op
    assign illegal_o = op_valid && !hit_o;

endmodule : csr_op_decoder

/* csr_pkg.sv */
package csr_pkg;

    // Machine-mode CSR block definitions

    // Data word and address widths follow the RV32 CSR space
    localparam int unsigned XLEN = 32;
    localparam int unsigned CSR_ADDR_W = 12;

    // One CSR data word
    typedef logic [XLEN-1:0] csr_word_t;

    // One CSR address as carried in the instruction
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // CSR instruction opcodes
    // CSR_NONE means no CSR instruction this cycle
    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // Number of implemented CSR slots
    localparam int unsigned NUM_CSR = 4;

    // Slot numbering
    // Slot order matches the address and mask tables below
    localparam int unsigned MSTATUS_SLOT = 0;
    localparam int unsigned MTVEC_SLOT   = 1;
    localparam int unsigned MEPC_SLOT    = 2;
    localparam int unsigned MCAUSE_SLOT  = 3;

    // CSR address of every slot
    localparam csr_addr_t CSR_ADDR [NUM_CSR] = '{
        12'h300,    // mstatus
        12'h305,    // mtvec
        12'h341,    // mepc
        12'h342     // mcause
    };

    // Writable bits of every slot
    // Bits outside the mask are hardwired to zero
    localparam csr_word_t CSR_WMASK [NUM_CSR] = '{
        // mstatus keeps MIE, MPIE and MPP
        32'h0000_1888,
        // mtvec base is word aligned and mode bits stay zero
        32'hFFFF_FFFC,
        // mepc is at least halfword aligned
        32'hFFFF_FFFE,
        // mcause is fully writable
        32'hFFFF_FFFF
    };

endpackage : csr_pkg
